/* id_pkg.sv */
/*
  Shared definitions for the decode stage: widths, opcode and ALU enums,
  operand and writeback selectors, and the packets between the blocks
*/
`default_nettype none

package id_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_REGS = 32;
  localparam int unsigned REG_AW   = 5;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'b011_0011,
    OPCODE_OP_IMM = 7'b001_0011,
    OPCODE_LUI    = 7'b011_0111,
    OPCODE_AUIPC  = 7'b001_0111,
    OPCODE_LOAD   = 7'b000_0011,
    OPCODE_STORE  = 7'b010_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  // Source of the register write data
  typedef enum logic {
    WB_EX,
    WB_LSU
  } wb_sel_e;

  ////////////////////////////////////////
  // Packets
  ////////////////////////////////////////

  typedef struct packed {
    logic              illegal;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              rd_we;
    alu_op_e           alu_op;
    op_a_sel_e         op_a_sel;
    op_b_sel_e         op_b_sel;
    logic [XLEN-1:0]   imm;
    logic              data_req;
    logic              data_we;
    wb_sel_e           wb_sel;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } instr_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            data_req;
    logic            data_we;
    logic [XLEN-1:0] store_data;
  } ex_req_t;

  typedef struct packed {
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] lsu_result;
  } wb_t;

endpackage

`default_nettype wire

/* id_regfile.sv */
/*
  Integer register file, two combinational read ports and one write port,
  x0 hardwired to zero
*/
`timescale 1ns/1ps
`default_nettype none

module id_regfile import id_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic [REG_AW-1:0] raddr_a_i,
  input  wire logic [REG_AW-1:0] raddr_b_i,
  output logic      [XLEN-1:0]   rdata_a_o,
  output logic      [XLEN-1:0]   rdata_b_o,
  input  wire logic [REG_AW-1:0] waddr_i,
  input  wire logic [XLEN-1:0]   wdata_i,
  input  wire logic              we_i
);

  logic [XLEN-1:0] rf_q [NUM_REGS];

  // x0 is a constant, no storage behind it
  assign rf_q[0] = '0;

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_i && (waddr_i == REG_AW'(i))) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

`default_nettype wire

/* id_decoder.sv */
/*
  Instruction decoder for the integer subset: ALU ops, LUI, AUIPC,
  word loads and stores, with immediate generation and illegal detection
*/
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
  input  wire logic [XLEN-1:0] instr_word_i,
  output decode_t              dec_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;

  assign opcode = opcode_e'(instr_word_i[6:0]);
  assign funct3 = instr_word_i[14:12];
  assign funct7 = instr_word_i[31:25];

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  assign imm_i_type = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
  assign imm_s_type = {{20{instr_word_i[31]}}, instr_word_i[31:25], instr_word_i[11:7]};
  assign imm_u_type = {instr_word_i[31:12], 12'b0};

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    // Defaults suit an I-type ALU op
    dec_o          = '0;
    dec_o.rs1      = instr_word_i[19:15];
    dec_o.rs2      = instr_word_i[24:20];
    dec_o.rd       = instr_word_i[11:7];
    dec_o.alu_op   = ALU_ADD;
    dec_o.op_a_sel = OP_A_REG;
    dec_o.op_b_sel = OP_B_IMM;
    dec_o.imm      = imm_i_type;
    dec_o.wb_sel   = WB_EX;

    unique case (opcode)
      OPCODE_OP: begin
        dec_o.op_b_sel = OP_B_REG;
        dec_o.rd_we    = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          default:         dec_o.illegal = 1'b1;
        endcase
      end

      OPCODE_OP_IMM: begin
        dec_o.rd_we = 1'b1;
        unique case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'h00);
          end
          3'b101: begin
            // Shift type sits in the upper immediate bits
            if (funct7 == 7'h00) begin
              dec_o.alu_op = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              dec_o.alu_op = ALU_SRA;
            end else begin
              dec_o.illegal = 1'b1;
            end
          end
        endcase
      end

      OPCODE_LUI, OPCODE_AUIPC: begin
        dec_o.op_a_sel = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.imm      = imm_u_type;
        dec_o.rd_we    = 1'b1;
      end

      OPCODE_LOAD: begin
        dec_o.data_req = 1'b1;
        dec_o.rd_we    = 1'b1;
        dec_o.wb_sel   = WB_LSU;
        dec_o.illegal  = (funct3 != 3'b010);
      end

      OPCODE_STORE: begin
        dec_o.imm      = imm_s_type;
        dec_o.data_req = 1'b1;
        dec_o.data_we  = 1'b1;
        dec_o.illegal  = (funct3 != 3'b010);
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // Nothing leaves the stage for an illegal word
    if (dec_o.illegal) begin
      dec_o.rd_we    = 1'b0;
      dec_o.data_req = 1'b0;
      dec_o.data_we  = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* id_operand_mux.sv */
/*
  ALU operand selection and assembly of the request to execute and LSU
*/
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux import id_pkg::*; (
  input  decode_t              dec_i,
  input  wire logic [XLEN-1:0] pc_i,
  input  wire logic [XLEN-1:0] rdata_a_i,
  input  wire logic [XLEN-1:0] rdata_b_i,
  output ex_req_t              ex_req_o
);

  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;

  ////////////////////////////////////////
  // Operand A
  ////////////////////////////////////////

  always_comb begin
    unique case (dec_i.op_a_sel)
      OP_A_REG: operand_a = rdata_a_i;
      OP_A_PC:  operand_a = pc_i;
      // LUI adds its immediate to zero
      default:  operand_a = '0;
    endcase
  end

  ////////////////////////////////////////
  // Operand B
  ////////////////////////////////////////

  assign operand_b = (dec_i.op_b_sel == OP_B_IMM) ? dec_i.imm : rdata_b_i;

  // Request to execute side
  assign ex_req_o.alu_op     = dec_i.alu_op;
  assign ex_req_o.operand_a  = operand_a;
  assign ex_req_o.operand_b  = operand_b;
  assign ex_req_o.data_req   = dec_i.data_req;
  assign ex_req_o.data_we    = dec_i.data_we;
  assign ex_req_o.store_data = rdata_b_i;

endmodule

`default_nettype wire

/* id_issue_fsm.sv */
/*
  Issue control: instruction register, input, issue and writeback
  handshakes, register file write control
*/
`timescale 1ns/1ps
`default_nettype none

module id_issue_fsm import id_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              instr_valid_i,
  input  instr_t                 instr_i,
  output logic                   instr_ready_o,
  output logic      [XLEN-1:0]   instr_word_o,
  output logic      [XLEN-1:0]   pc_o,
  input  decode_t                dec_i,
  output logic                   ex_valid_o,
  input  wire logic              ex_ready_i,
  input  wire logic              wb_valid_i,
  input  wb_t                    wb_i,
  output logic                   rf_we_o,
  output logic      [REG_AW-1:0] rf_waddr_o,
  output logic      [XLEN-1:0]   rf_wdata_o,
  output logic                   illegal_insn_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } state_e;

  state_e state_q;
  state_e state_d;
  instr_t instr_q;

  ////////////////////////////////////////
  // State and instruction registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Held for the whole instruction, so decode stays stable
  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      instr_q <= instr_i;
    end
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (instr_valid_i) begin
          state_d = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        if (dec_i.illegal) begin
          state_d = ST_IDLE;
        end else if (ex_ready_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (wb_valid_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Handshakes
  assign instr_ready_o  = (state_q == ST_IDLE);
  assign ex_valid_o     = (state_q == ST_ISSUE) && !dec_i.illegal;
  assign illegal_insn_o = (state_q == ST_ISSUE) && dec_i.illegal;

  assign instr_word_o = instr_q.instr;
  assign pc_o         = instr_q.pc;

  // Writeback on the result edge, x0 filtered in the register file
  assign rf_we_o    = (state_q == ST_WAIT) && wb_valid_i && dec_i.rd_we;
  assign rf_waddr_o = dec_i.rd;
  assign rf_wdata_o = (dec_i.wb_sel == WB_LSU) ? wb_i.lsu_result : wb_i.ex_result;

endmodule

`default_nettype wire

/* id_stage_top.sv */
/*
  Decode stage top: issue FSM, decoder, register file and operand mux
*/
`timescale 1ns/1ps
`default_nettype none

module id_stage_top import id_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic instr_valid_i,
  input  instr_t    instr_i,
  output logic      instr_ready_o,
  output logic      ex_valid_o,
  output ex_req_t   ex_req_o,
  input  wire logic ex_ready_i,
  input  wire logic wb_valid_i,
  input  wb_t       wb_i,
  output logic      illegal_insn_o
);

  logic [XLEN-1:0]   instr_word;
  logic [XLEN-1:0]   pc;
  decode_t           dec;
  logic [XLEN-1:0]   rdata_a;
  logic [XLEN-1:0]   rdata_b;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;

  id_issue_fsm id_issue_fsm_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .instr_word_o   (instr_word),
    .pc_o           (pc),
    .dec_i          (dec),
    .ex_valid_o     (ex_valid_o),
    .ex_ready_i     (ex_ready_i),
    .wb_valid_i     (wb_valid_i),
    .wb_i           (wb_i),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .illegal_insn_o (illegal_insn_o)
  );

  id_decoder id_decoder_inst (
    .instr_word_i (instr_word),
    .dec_o        (dec)
  );

  id_regfile id_regfile_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  id_operand_mux id_operand_mux_inst (
    .dec_i     (dec),
    .pc_i      (pc),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .ex_req_o  (ex_req_o)
  );

endmodule

`default_nettype wire

/* tb_id_stage.sv */
/*
  Testbench for the decode stage: execute-side model with random stalls,
  register and ALU models, assertion-based checks
*/
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  logic    clk_i;
  logic    rst_ni;
  logic    instr_valid_i;
  instr_t  instr_i;
  logic    instr_ready_o;
  logic    ex_valid_o;
  ex_req_t ex_req_o;
  logic    ex_ready_i;
  logic    wb_valid_i;
  wb_t     wb_i;
  logic    illegal_insn_o;

  logic [XLEN-1:0] reg_model [NUM_REGS];
  logic [31:0]     rng_state;
  int              error_count;
  int              tests_passed;
  int              tests_failed;
  int              min_stall;

  id_stage_top id_stage_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_req_o       (ex_req_o),
    .ex_ready_i     (ex_ready_i),
    .wb_valid_i     (wb_valid_i),
    .wb_i           (wb_i),
    .illegal_insn_o (illegal_insn_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Protocol properties
  ////////////////////////////////////////

  hold_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_req_o))
    else report_mismatch("ex_req_o changed or ex_valid_o dropped under back-pressure");
  one_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |=> !illegal_insn_o)
    else report_mismatch("illegal_insn_o high for more than one cycle");
  no_issue_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |-> !ex_valid_o)
    else report_mismatch("ex_valid_o high together with illegal_insn_o");
  busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_valid_o |-> !instr_ready_o)
    else report_mismatch("instr_ready_o high while a request is pending");

  ////////////////////////////////////////
  // Models and encoders
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'd0, a < b};
      default:  return a + b;
    endcase
  endfunction

  function automatic logic [31:0] sext_imm12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b011_0011};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift(rng_state);
    value     = rng_state;
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic wait_instr_ready();
    int cycles;
    cycles = 0;
    while (!instr_ready_o && cycles < 100) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!instr_ready_o) begin
      $display("Timeout: instr_ready_o never went high, the stage is stuck");
      $display("sim failed");
      $finish;
    end
  endtask

  ////////////////////////////////////////
  // Execute-side model
  ////////////////////////////////////////

  // One instruction through accept, issue, stall and writeback
  task automatic run_instr(input logic [31:0] word, input logic [31:0] pc, input logic legal,
                           input ex_req_t exp_req, input logic [4:0] rd, input logic rd_we);
    ex_req_t     seen;
    logic [31:0] r;
    logic [31:0] lsu_value;
    int          stall;
    wait_instr_ready();
    instr_valid_i = 1'b1;
    instr_i       = '{instr: word, pc: pc};
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    instr_i       = '0;
    if (!legal) begin
      assert (illegal_insn_o && !ex_valid_o)
        else report_mismatch($sformatf("word %h not flagged illegal, or issued", word));
      @(negedge clk_i);
      assert (instr_ready_o && !illegal_insn_o)
        else report_mismatch("stage not ready again after illegal word");
    end else begin
      assert (ex_valid_o) else report_mismatch("ex_valid_o low in the cycle after accept");
      assert (ex_req_o.alu_op == exp_req.alu_op)
        else report_mismatch($sformatf("alu_op %0d, expected %0d", ex_req_o.alu_op,
                                       exp_req.alu_op));
      assert (ex_req_o.operand_a == exp_req.operand_a)
        else report_mismatch($sformatf("operand_a %h, expected %h", ex_req_o.operand_a,
                                       exp_req.operand_a));
      assert (ex_req_o.operand_b == exp_req.operand_b)
        else report_mismatch($sformatf("operand_b %h, expected %h", ex_req_o.operand_b,
                                       exp_req.operand_b));
      assert (ex_req_o.data_req == exp_req.data_req && ex_req_o.data_we == exp_req.data_we)
        else report_mismatch("data_req or data_we wrong");
      assert (!exp_req.data_we || ex_req_o.store_data == exp_req.store_data)
        else report_mismatch($sformatf("store_data %h, expected %h", ex_req_o.store_data,
                                       exp_req.store_data));
      next_random(r);
      stall = min_stall + int'(r % 4);
      for (int i = 0; i < stall; i++) begin
        @(negedge clk_i);
        assert (ex_valid_o && !instr_ready_o) else report_mismatch("request lost while stalled");
      end
      seen       = ex_req_o;
      ex_ready_i = 1'b1;
      @(negedge clk_i);
      ex_ready_i = 1'b0;
      next_random(lsu_value);
      next_random(r);
      stall = int'(r % 4);
      for (int i = 0; i < stall; i++) begin
        assert (!instr_ready_o && !ex_valid_o)
          else report_mismatch("stage active while waiting for the result");
        @(negedge clk_i);
      end
      wb_valid_i = 1'b1;
      wb_i       = '{ex_result: alu_model(seen.alu_op, seen.operand_a, seen.operand_b),
                     lsu_result: lsu_value};
      @(negedge clk_i);
      wb_valid_i = 1'b0;
      wb_i       = '0;
      if (rd_we && rd != 5'd0) begin
        reg_model[rd] = exp_req.data_req ? lsu_value :
                        alu_model(exp_req.alu_op, exp_req.operand_a, exp_req.operand_b);
      end
      assert (instr_ready_o) else report_mismatch("instr_ready_o low after writeback");
    end
  endtask

  // ADD x0, xr, x0 for every r shows the whole register file
  task automatic read_back_regs();
    ex_req_t exp_req;
    for (int r = 0; r < NUM_REGS; r++) begin
      exp_req           = '0;
      exp_req.alu_op    = ALU_ADD;
      exp_req.operand_a = reg_model[r];
      run_instr(r_word(7'h00, 5'd0, r[4:0], 3'b000, 5'd0), 32'h100, 1'b1, exp_req, 5'd0, 1'b1);
    end
  endtask

  // Random ADDI, XORI, SLTI, ADD, SUB or SRA
  task automatic alu_case(input int kind);
    ex_req_t     exp_req;
    logic [31:0] r;
    logic [31:0] word;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [11:0] imm;
    next_random(r);
    rs1               = r[4:0];
    rs2               = r[9:5];
    rd                = r[14:10];
    imm               = r[26:15];
    exp_req           = '0;
    exp_req.operand_a = reg_model[rs1];
    exp_req.operand_b = (kind < 3) ? sext_imm12(imm) : reg_model[rs2];
    case (kind)
      0: exp_req.alu_op = ALU_ADD;
      1: exp_req.alu_op = ALU_XOR;
      2: exp_req.alu_op = ALU_SLT;
      3: exp_req.alu_op = ALU_ADD;
      4: exp_req.alu_op = ALU_SUB;
      default: exp_req.alu_op = ALU_SRA;
    endcase
    case (kind)
      0: word = i_word(imm, rs1, 3'b000, rd, OPCODE_OP_IMM);
      1: word = i_word(imm, rs1, 3'b100, rd, OPCODE_OP_IMM);
      2: word = i_word(imm, rs1, 3'b010, rd, OPCODE_OP_IMM);
      3: word = r_word(7'h00, rs2, rs1, 3'b000, rd);
      4: word = r_word(7'h20, rs2, rs1, 3'b000, rd);
      default: word = r_word(7'h20, rs2, rs1, 3'b101, rd);
    endcase
    next_random(r);
    run_instr(word, {r[31:2], 2'b00}, 1'b1, exp_req, rd, 1'b1);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int          errors_before;
    ex_req_t     exp_req;
    logic [31:0] r;
    logic [31:0] pc;
    logic [4:0]  rd;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ex_ready_i    = 1'b0;
    wb_valid_i    = 1'b0;
    wb_i          = '0;
    rng_state     = 32'd12;
    error_count   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    min_stall     = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      reg_model[i] = '0;
    end

    errors_before = error_count;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (instr_ready_o && !ex_valid_o && !illegal_insn_o)
      else report_mismatch("outputs not idle after reset");
    finish_test("reset", errors_before);

    errors_before = error_count;
    for (int n = 0; n < 24; n++) begin
      alu_case(n % 6);
    end
    // Write to x0 must be dropped
    exp_req           = '0;
    exp_req.alu_op    = ALU_ADD;
    exp_req.operand_a = reg_model[1];
    exp_req.operand_b = 32'h123;
    run_instr(i_word(12'h123, 5'd1, 3'b000, 5'd0, OPCODE_OP_IMM), 32'h0, 1'b1, exp_req, 5'd0,
              1'b1);
    read_back_regs();
    finish_test("alu", errors_before);

    errors_before = error_count;
    for (int n = 0; n < 4; n++) begin
      next_random(r);
      next_random(pc);
      pc[1:0]           = 2'b00;
      rd                = r[4:0];
      exp_req           = '0;
      exp_req.alu_op    = ALU_ADD;
      exp_req.operand_a = (n % 2 == 0) ? 32'd0 : pc;
      exp_req.operand_b = {r[31:12], 12'h000};
      run_instr(u_word(r[31:12], rd, (n % 2 == 0) ? OPCODE_LUI : OPCODE_AUIPC), pc, 1'b1,
                exp_req, rd, 1'b1);
    end
    finish_test("lui_auipc", errors_before);

    errors_before = error_count;
    for (int n = 0; n < 8; n++) begin
      next_random(r);
      exp_req           = '0;
      exp_req.alu_op    = ALU_ADD;
      exp_req.operand_a = reg_model[r[4:0]];
      exp_req.operand_b = sext_imm12(r[26:15]);
      exp_req.data_req  = 1'b1;
      if (n % 2 == 0) begin
        run_instr(i_word(r[26:15], r[4:0], 3'b010, r[14:10], OPCODE_LOAD), 32'h200, 1'b1,
                  exp_req, r[14:10], 1'b1);
      end else begin
        exp_req.data_we    = 1'b1;
        exp_req.store_data = reg_model[r[9:5]];
        run_instr(s_word(r[26:15], r[9:5], r[4:0], 3'b010), 32'h204, 1'b1, exp_req, 5'd0,
                  1'b0);
      end
    end
    read_back_regs();
    finish_test("load_store", errors_before);

    errors_before = error_count;
    min_stall     = 4;
    for (int n = 0; n < 6; n++) begin
      alu_case(3 + n % 3);
    end
    min_stall = 0;
    finish_test("backpressure", errors_before);

    errors_before = error_count;
    next_random(r);
    run_instr({r[31:7], 7'h7F}, 32'h300, 1'b0, '0, 5'd0, 1'b0);
    run_instr(i_word(r[26:15], r[4:0], 3'b000, r[14:10], OPCODE_LOAD), 32'h304, 1'b0, '0,
              5'd0, 1'b0);
    read_back_regs();
    finish_test("illegal", errors_before);

    $display("Tests ok: %0d, tests with errors: %0d, total errors: %0d", tests_passed,
             tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
id_pkg.sv
id_regfile.sv
id_decoder.sv
id_operand_mux.sv
id_issue_fsm.sv
id_stage_top.sv
tb_id_stage.sv
